// File: rtl/bfp_pkg.sv
package bfp_pkg;

    // ----------------------------------------
    // Default configuration
    // ----------------------------------------
    parameter int DEF_NUM_CH  = 4;
    parameter int DEF_IW      = 24;
    parameter int DEF_OW      = 12;
    parameter int DEF_PKT_LEN = 16;

    // Stages beyond the packet length, total latency is PKT_LEN + PIPE_EXTRA
    parameter int PIPE_EXTRA  = 4;

    // ----------------------------------------
    // Shared types
    // ----------------------------------------
    // Block shift amount, covers IW up to 32
    typedef logic [4:0] shift_t;

    // Per-channel gain word
    typedef logic [7:0] agc_t;

    // Strobes packed as {sel, sop, eop, vld}
    typedef logic [3:0] strobe_t;

endpackage

// File: rtl/channel_peak_detect.sv
`timescale 1ns/1ps

module channel_peak_detect #(
    parameter int IW = 24
) (
    input  logic          clk,
    input  logic          i_rst_n,
    input  logic          i_sop,
    input  logic          i_eop,
    input  logic          i_vld,
    input  logic [IW-1:0] i_din_re,
    input  logic [IW-1:0] i_din_im,
    output logic [IW-2:0] o_peak,
    output logic          o_peak_stb
);

    logic [IW-2:0] mag_re;
    logic [IW-2:0] mag_im;
    logic [IW-2:0] beat_or;
    logic [IW-2:0] peak_acc;
    logic [IW-2:0] peak_next;

    // One's-complement magnitude, negative values just get inverted
    assign mag_re = i_din_re[IW-1] ? ~i_din_re[IW-2:0] : i_din_re[IW-2:0];
    assign mag_im = i_din_im[IW-1] ? ~i_din_im[IW-2:0] : i_din_im[IW-2:0];

    assign beat_or = mag_re | mag_im;

    // Start of packet restarts the accumulation
    assign peak_next = i_sop ? beat_or : (peak_acc | beat_or);

    always_ff @(posedge clk) begin
        if (i_vld) begin
            peak_acc <= peak_next;
        end
        if (i_vld && i_eop) begin
            o_peak <= peak_next;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_peak_stb <= 1'b0;
        end else begin
            o_peak_stb <= i_vld && i_eop;
        end
    end

endmodule

// File: rtl/block_exponent.sv
`timescale 1ns/1ps

module block_exponent #(
    parameter int NUM_CH = 4,
    parameter int IW     = 24,
    parameter int OW     = 12
) (
    input  logic                           clk,
    input  logic                           i_rst_n,
    input  logic [NUM_CH-1:0][IW-2:0]      i_peak,
    input  logic                           i_peak_stb,
    output bfp_pkg::shift_t                o_shift_new,
    output logic                           o_shift_stb
);

    logic [IW-2:0]   chan_or;
    logic [IW-2:0]   peak_or;
    logic            or_stb;
    int              top_bit;
    logic            found;
    bfp_pkg::shift_t shift_calc;

    // ----------------------------------------
    // Stage 1: OR across all channels
    // ----------------------------------------
    always_comb begin
        chan_or = '0;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            chan_or = chan_or | i_peak[ch];
        end
    end

    always_ff @(posedge clk) begin
        peak_or <= chan_or;
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            or_stb <= 1'b0;
        end else begin
            or_stb <= i_peak_stb;
        end
    end

    // ----------------------------------------
    // Stage 2: highest set bit to shift
    // ----------------------------------------
    // Scan upward so the last hit is the MSB
    always_comb begin
        top_bit = 0;
        found   = 1'b0;
        for (int i = 0; i < IW-1; i++) begin
            if (peak_or[i]) begin
                top_bit = i;
                found   = 1'b1;
            end
        end
        // Keep p+1 magnitude bits plus sign inside OW
        if (found && (top_bit + 2 > OW)) begin
            shift_calc = bfp_pkg::shift_t'(top_bit + 2 - OW);
        end else begin
            shift_calc = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_shift_new <= '0;
            o_shift_stb <= 1'b0;
        end else begin
            o_shift_stb <= or_stb;
            if (or_stb) begin
                o_shift_new <= shift_calc;
            end
        end
    end

endmodule

// File: rtl/sample_delay_line.sv
`timescale 1ns/1ps

module sample_delay_line #(
    parameter int NUM_CH = 4,
    parameter int IW     = 24,
    parameter int DEPTH  = 19
) (
    input  logic                              clk,
    input  logic                              i_rst_n,
    input  bfp_pkg::strobe_t                  i_strobe,
    input  logic [NUM_CH-1:0][IW-1:0]         i_din_re,
    input  logic [NUM_CH-1:0][IW-1:0]         i_din_im,
    input  bfp_pkg::agc_t [NUM_CH-1:0]        i_agc,
    output bfp_pkg::strobe_t                  o_strobe,
    output logic [NUM_CH-1:0][IW-1:0]         o_din_re,
    output logic [NUM_CH-1:0][IW-1:0]         o_din_im,
    output bfp_pkg::agc_t [NUM_CH-1:0]        o_agc
);

    // Index 0 is the newest entry
    bfp_pkg::strobe_t [DEPTH-1:0]              strobe_pipe;
    logic [DEPTH-1:0][NUM_CH-1:0][IW-1:0]      re_pipe;
    logic [DEPTH-1:0][NUM_CH-1:0][IW-1:0]      im_pipe;
    bfp_pkg::agc_t [DEPTH-1:0][NUM_CH-1:0]     agc_pipe;

    // ----------------------------------------
    // Strobe chain
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            strobe_pipe <= '0;
        end else begin
            strobe_pipe <= {strobe_pipe[DEPTH-2:0], i_strobe};
        end
    end

    // ----------------------------------------
    // Payload chain
    // ----------------------------------------
    always_ff @(posedge clk) begin
        re_pipe  <= {re_pipe[DEPTH-2:0], i_din_re};
        im_pipe  <= {im_pipe[DEPTH-2:0], i_din_im};
        agc_pipe <= {agc_pipe[DEPTH-2:0], i_agc};
    end

    assign o_strobe = strobe_pipe[DEPTH-1];
    assign o_din_re = re_pipe[DEPTH-1];
    assign o_din_im = im_pipe[DEPTH-1];
    assign o_agc    = agc_pipe[DEPTH-1];

endmodule

// File: rtl/block_shifter.sv
`timescale 1ns/1ps

module block_shifter #(
    parameter int NUM_CH = 4,
    parameter int IW     = 24,
    parameter int OW     = 12
) (
    input  logic                           clk,
    input  logic                           i_rst_n,
    input  bfp_pkg::shift_t                i_shift_new,
    input  logic                           i_shift_stb,
    input  bfp_pkg::strobe_t               i_strobe,
    input  logic [NUM_CH-1:0][IW-1:0]      i_din_re,
    input  logic [NUM_CH-1:0][IW-1:0]      i_din_im,
    input  bfp_pkg::agc_t [NUM_CH-1:0]     i_agc,
    output logic                           o_sel,
    output logic                           o_sop,
    output logic                           o_eop,
    output logic                           o_vld,
    output logic [NUM_CH-1:0][OW-1:0]      o_dout_re,
    output logic [NUM_CH-1:0][OW-1:0]      o_dout_im,
    output bfp_pkg::shift_t                o_shift,
    output bfp_pkg::agc_t [NUM_CH-1:0]     o_agc
);

    bfp_pkg::shift_t              shift_pending;
    bfp_pkg::shift_t              shift_active;
    bfp_pkg::shift_t              shift_use;
    logic                         pkt_start;
    logic [NUM_CH-1:0][IW-1:0]    shr_re;
    logic [NUM_CH-1:0][IW-1:0]    shr_im;

    // Strobe order is {sel, sop, eop, vld}
    assign pkt_start = i_strobe[2] && i_strobe[0];

    // ----------------------------------------
    // Pending and active shift
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            shift_pending <= '0;
            shift_active  <= '0;
        end else begin
            if (i_shift_stb) begin
                shift_pending <= i_shift_new;
            end
            if (pkt_start) begin
                shift_active <= shift_pending;
            end
        end
    end

    // First beat of a packet already needs the new value
    assign shift_use = pkt_start ? shift_pending : shift_active;

    // ----------------------------------------
    // Arithmetic shift per channel
    // ----------------------------------------
    genvar g;
    generate
        for (g = 0; g < NUM_CH; g++) begin : g_shr
            assign shr_re[g] = $signed(i_din_re[g]) >>> shift_use;
            assign shr_im[g] = $signed(i_din_im[g]) >>> shift_use;
        end
    endgenerate

    always_ff @(posedge clk) begin
        for (int ch = 0; ch < NUM_CH; ch++) begin
            o_dout_re[ch] <= shr_re[ch][OW-1:0];
            o_dout_im[ch] <= shr_im[ch][OW-1:0];
            // Gain word tracks the exponent, wraps mod 256
            o_agc[ch]     <= i_agc[ch] + bfp_pkg::agc_t'(shift_use);
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_sel   <= 1'b0;
            o_sop   <= 1'b0;
            o_eop   <= 1'b0;
            o_vld   <= 1'b0;
            o_shift <= '0;
        end else begin
            o_sel   <= i_strobe[3];
            o_sop   <= i_strobe[2];
            o_eop   <= i_strobe[1];
            o_vld   <= i_strobe[0];
            o_shift <= shift_use;
        end
    end

endmodule

// File: rtl/bfp_compress_top.sv
`timescale 1ns/1ps

module bfp_compress_top #(
    parameter int NUM_CH  = bfp_pkg::DEF_NUM_CH,
    parameter int IW      = bfp_pkg::DEF_IW,
    parameter int OW      = bfp_pkg::DEF_OW,
    parameter int PKT_LEN = bfp_pkg::DEF_PKT_LEN
) (
    input  logic                           clk,
    input  logic                           i_rst_n,
    input  logic                           i_sel,
    input  logic                           i_sop,
    input  logic                           i_eop,
    input  logic                           i_vld,
    input  logic [NUM_CH-1:0][IW-1:0]      i_din_re,
    input  logic [NUM_CH-1:0][IW-1:0]      i_din_im,
    input  bfp_pkg::agc_t [NUM_CH-1:0]     i_agc,
    output logic                           o_sel,
    output logic                           o_sop,
    output logic                           o_eop,
    output logic                           o_vld,
    output logic [NUM_CH-1:0][OW-1:0]      o_dout_re,
    output logic [NUM_CH-1:0][OW-1:0]      o_dout_im,
    output bfp_pkg::shift_t                o_shift,
    output bfp_pkg::agc_t [NUM_CH-1:0]     o_agc
);

    // Total latency, the shifter register takes the last cycle
    localparam int LATENCY   = PKT_LEN + bfp_pkg::PIPE_EXTRA;
    localparam int DLY_DEPTH = LATENCY - 1;

    logic [NUM_CH-1:0][IW-2:0]     peak;
    logic                          peak_stb;
    bfp_pkg::shift_t               shift_new;
    logic                          shift_stb;
    bfp_pkg::strobe_t              dly_strobe;
    logic [NUM_CH-1:0][IW-1:0]     dly_re;
    logic [NUM_CH-1:0][IW-1:0]     dly_im;
    bfp_pkg::agc_t [NUM_CH-1:0]    dly_agc;

    // ----------------------------------------
    // Per-channel peak detection
    // ----------------------------------------
    // All channels share timing, channel 0 supplies the strobe
    genvar g;
    generate
        for (g = 0; g < NUM_CH; g++) begin : g_peak
            if (g == 0) begin : g_lead
                channel_peak_detect #(
                    .IW         (IW)
                ) u_peak (
                    .clk        (clk),
                    .i_rst_n    (i_rst_n),
                    .i_sop      (i_sop),
                    .i_eop      (i_eop),
                    .i_vld      (i_vld),
                    .i_din_re   (i_din_re[g]),
                    .i_din_im   (i_din_im[g]),
                    .o_peak     (peak[g]),
                    .o_peak_stb (peak_stb)
                );
            end else begin : g_follow
                channel_peak_detect #(
                    .IW         (IW)
                ) u_peak (
                    .clk        (clk),
                    .i_rst_n    (i_rst_n),
                    .i_sop      (i_sop),
                    .i_eop      (i_eop),
                    .i_vld      (i_vld),
                    .i_din_re   (i_din_re[g]),
                    .i_din_im   (i_din_im[g]),
                    .o_peak     (peak[g]),
                    .o_peak_stb ()
                );
            end
        end
    endgenerate

    // ----------------------------------------
    // Packet exponent
    // ----------------------------------------
    block_exponent #(
        .NUM_CH      (NUM_CH),
        .IW          (IW),
        .OW          (OW)
    ) u_exponent (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_peak      (peak),
        .i_peak_stb  (peak_stb),
        .o_shift_new (shift_new),
        .o_shift_stb (shift_stb)
    );

    // ----------------------------------------
    // Sample delay and shift
    // ----------------------------------------
    sample_delay_line #(
        .NUM_CH   (NUM_CH),
        .IW       (IW),
        .DEPTH    (DLY_DEPTH)
    ) u_delay (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_strobe ({i_sel, i_sop, i_eop, i_vld}),
        .i_din_re (i_din_re),
        .i_din_im (i_din_im),
        .i_agc    (i_agc),
        .o_strobe (dly_strobe),
        .o_din_re (dly_re),
        .o_din_im (dly_im),
        .o_agc    (dly_agc)
    );

    block_shifter #(
        .NUM_CH      (NUM_CH),
        .IW          (IW),
        .OW          (OW)
    ) u_shifter (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_shift_new (shift_new),
        .i_shift_stb (shift_stb),
        .i_strobe    (dly_strobe),
        .i_din_re    (dly_re),
        .i_din_im    (dly_im),
        .i_agc       (dly_agc),
        .o_sel       (o_sel),
        .o_sop       (o_sop),
        .o_eop       (o_eop),
        .o_vld       (o_vld),
        .o_dout_re   (o_dout_re),
        .o_dout_im   (o_dout_im),
        .o_shift     (o_shift),
        .o_agc       (o_agc)
    );

endmodule

// File: test/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD = 100
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
    end

    // Free running, half period per phase
    always begin
        #(PERIOD / 2) o_clk = ~o_clk;
    end

endmodule

// File: test/bfp_compress_assertions.sv
`timescale 1ns/1ps

module bfp_compress_assertions #(
    parameter int LATENCY = 20
) (
    input logic            clk,
    input logic            i_rst_n,
    input logic            i_vld,
    input logic            o_vld,
    input logic            o_sop,
    input logic            o_eop,
    input bfp_pkg::shift_t o_shift
);

    int cyc;

    // Cycles since reset, saturates once the pipeline is full
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            cyc <= 0;
        end else if (cyc < LATENCY + 1) begin
            cyc <= cyc + 1;
        end
    end

    // Valid comes out exactly LATENCY cycles after it went in
    vld_latency: assert property (@(posedge clk) disable iff (!i_rst_n)
        (cyc > LATENCY) |-> (o_vld == $past(i_vld, LATENCY)))
        else $error("o_vld does not follow i_vld by %0d cycles", LATENCY);

    sop_eop_in_vld: assert property (@(posedge clk) disable iff (!i_rst_n)
        (o_sop || o_eop) |-> o_vld)
        else $error("o_sop or o_eop seen without o_vld");

    // Inside a packet every beat after sop keeps the same shift
    shift_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
        (o_vld && !o_sop && $past(o_vld)) |-> (o_shift == $past(o_shift)))
        else $error("o_shift changed inside a packet");

endmodule

// File: test/tb_checker.sv
`timescale 1ns/1ps

module tb_checker #(
    parameter int NUM_CH  = 4,
    parameter int IW      = 24,
    parameter int OW      = 12,
    parameter int PKT_LEN = 16
) (
    input  logic                          clk,
    input  logic                          i_rst_n,
    input  logic                          i_in_sel,
    input  logic                          i_in_sop,
    input  logic                          i_in_eop,
    input  logic                          i_in_vld,
    input  logic [NUM_CH-1:0][IW-1:0]     i_in_re,
    input  logic [NUM_CH-1:0][IW-1:0]     i_in_im,
    input  bfp_pkg::agc_t [NUM_CH-1:0]    i_in_agc,
    input  logic                          i_out_sel,
    input  logic                          i_out_sop,
    input  logic                          i_out_eop,
    input  logic                          i_out_vld,
    input  logic [NUM_CH-1:0][OW-1:0]     i_out_re,
    input  logic [NUM_CH-1:0][OW-1:0]     i_out_im,
    input  bfp_pkg::shift_t               i_out_shift,
    input  bfp_pkg::agc_t [NUM_CH-1:0]    i_out_agc,
    output int                            o_errors,
    output int                            o_checks,
    output int                            o_beats_in,
    output int                            o_beats_out
);

    localparam int L = PKT_LEN + bfp_pkg::PIPE_EXTRA;

    // Input history, one entry per clock
    bfp_pkg::strobe_t              stb_hist[$];
    logic [NUM_CH-1:0][IW-1:0]     re_hist[$];
    logic [NUM_CH-1:0][IW-1:0]     im_hist[$];
    bfp_pkg::agc_t [NUM_CH-1:0]    agc_hist[$];
    bfp_pkg::shift_t               shift_q[$];

    logic [IW-2:0]   peak_acc;
    bfp_pkg::shift_t cur_r;
    bit              pkt_seen;
    int              err_cnt;
    int              chk_cnt;
    int              in_cnt;
    int              out_cnt;

    initial begin
        peak_acc = '0;
        cur_r    = '0;
        pkt_seen = 1'b0;
        err_cnt  = 0;
        chk_cnt  = 0;
        in_cnt   = 0;
        out_cnt  = 0;
    end

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic logic [IW-2:0] ones_mag(input logic [IW-1:0] x);
        if (x[IW-1]) begin
            return ~x[IW-2:0];
        end
        return x[IW-2:0];
    endfunction

    // Shift so that the top set bit plus sign fits in OW bits
    function automatic bfp_pkg::shift_t ref_shift(input logic [IW-2:0] peak);
        int p;
        int r;
        p = -1;
        for (int i = 0; i < IW - 1; i++) begin
            if (peak[i]) begin
                p = i;
            end
        end
        r = p + 2 - OW;
        if (r < 0) begin
            r = 0;
        end
        return bfp_pkg::shift_t'(r);
    endfunction

    function automatic logic [OW-1:0] ref_sample(input logic [IW-1:0] x, input int r);
        logic signed [IW-1:0] s;
        s = x;
        s = s >>> r;
        return s[OW-1:0];
    endfunction

    task automatic report_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        err_cnt++;
    endtask

    // ----------------------------------------
    // Capture and compare
    // ----------------------------------------
    always @(posedge clk) begin
        bfp_pkg::strobe_t           exp_stb;
        logic [NUM_CH-1:0][IW-1:0]  exp_re;
        logic [NUM_CH-1:0][IW-1:0]  exp_im;
        bfp_pkg::agc_t [NUM_CH-1:0] exp_agc;
        logic [IW-2:0]              beat_or;
        bfp_pkg::agc_t              agc_want;

        stb_hist.push_back({i_in_sel, i_in_sop, i_in_eop, i_in_vld});
        re_hist.push_back(i_in_re);
        im_hist.push_back(i_in_im);
        agc_hist.push_back(i_in_agc);

        if (i_in_vld) begin
            in_cnt++;
            beat_or = '0;
            for (int ch = 0; ch < NUM_CH; ch++) begin
                beat_or = beat_or | ones_mag(i_in_re[ch]) | ones_mag(i_in_im[ch]);
            end
            peak_acc = i_in_sop ? beat_or : (peak_acc | beat_or);
            if (i_in_eop) begin
                shift_q.push_back(ref_shift(peak_acc));
            end
        end

        if (stb_hist.size() > L) begin
            exp_stb = stb_hist.pop_front();
            exp_re  = re_hist.pop_front();
            exp_im  = im_hist.pop_front();
            exp_agc = agc_hist.pop_front();
        end else begin
            exp_stb = '0;
            exp_re  = '0;
            exp_im  = '0;
            exp_agc = '0;
        end

        if (i_rst_n) begin
            chk_cnt++;
            if (i_out_vld) begin
                out_cnt++;
            end
            if ({i_out_sel, i_out_sop, i_out_eop, i_out_vld} !== exp_stb) begin
                report_error($sformatf("strobes {sel,sop,eop,vld} got %b expected %b",
                    {i_out_sel, i_out_sop, i_out_eop, i_out_vld}, exp_stb));
            end
            if (exp_stb[0]) begin
                if (exp_stb[2]) begin
                    if (shift_q.size() == 0) begin
                        $display("Output packet started with no finished input packet");
                        err_cnt++;
                    end else begin
                        cur_r    = shift_q.pop_front();
                        pkt_seen = 1'b1;
                    end
                end
                if (i_out_shift !== cur_r) begin
                    report_error($sformatf("o_shift got %0d expected %0d", i_out_shift, cur_r));
                end
                for (int ch = 0; ch < NUM_CH; ch++) begin
                    agc_want = exp_agc[ch] + bfp_pkg::agc_t'(cur_r);
                    if (i_out_re[ch] !== ref_sample(exp_re[ch], cur_r)) begin
                        report_error($sformatf("ch %0d re got %h expected %h", ch,
                            i_out_re[ch], ref_sample(exp_re[ch], cur_r)));
                    end
                    if (i_out_im[ch] !== ref_sample(exp_im[ch], cur_r)) begin
                        report_error($sformatf("ch %0d im got %h expected %h", ch,
                            i_out_im[ch], ref_sample(exp_im[ch], cur_r)));
                    end
                    if (i_out_agc[ch] !== agc_want) begin
                        report_error($sformatf("ch %0d agc got %h expected %h", ch,
                            i_out_agc[ch], agc_want));
                    end
                end
            end else if (!pkt_seen && i_out_shift !== '0) begin
                report_error($sformatf("o_shift %0d before first packet", i_out_shift));
            end
        end

        o_errors    <= err_cnt;
        o_checks    <= chk_cnt;
        o_beats_in  <= in_cnt;
        o_beats_out <= out_cnt;
    end

endmodule

// File: test/tb_top.sv
`timescale 1ns/1ps

module tb_top;

    localparam int NUM_CH    = bfp_pkg::DEF_NUM_CH;
    localparam int IW        = bfp_pkg::DEF_IW;
    localparam int OW        = bfp_pkg::DEF_OW;
    localparam int PKT_LEN   = bfp_pkg::DEF_PKT_LEN;
    localparam int LATENCY   = PKT_LEN + bfp_pkg::PIPE_EXTRA;
    localparam int NUM_PKTS  = 17;
    localparam int NUM_TESTS = 6;
    // Packets with gaps, one drain per test, idle time and reset
    localparam int TIMEOUT_CYCLES = NUM_PKTS * (PKT_LEN + 2)
                                  + NUM_TESTS * (LATENCY + 20) + 40;

    logic                       clk;
    logic                       i_rst_n;
    logic                       i_sel;
    logic                       i_sop;
    logic                       i_eop;
    logic                       i_vld;
    logic [NUM_CH-1:0][IW-1:0]  i_din_re;
    logic [NUM_CH-1:0][IW-1:0]  i_din_im;
    bfp_pkg::agc_t [NUM_CH-1:0] i_agc;
    logic                       o_sel;
    logic                       o_sop;
    logic                       o_eop;
    logic                       o_vld;
    logic [NUM_CH-1:0][OW-1:0]  o_dout_re;
    logic [NUM_CH-1:0][OW-1:0]  o_dout_im;
    bfp_pkg::shift_t            o_shift;
    bfp_pkg::agc_t [NUM_CH-1:0] o_agc;
    int                         errors;
    int                         checks;
    int                         beats_in;
    int                         beats_out;
    int                         seed;
    int                         test_num;
    int                         errs_before;

    bind bfp_compress_top bfp_compress_assertions #(
        .LATENCY (PKT_LEN + bfp_pkg::PIPE_EXTRA)
    ) u_assertions (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_vld   (i_vld),
        .o_vld   (o_vld),
        .o_sop   (o_sop),
        .o_eop   (o_eop),
        .o_shift (o_shift)
    );

    tb_clock_gen #(.PERIOD(100)) u_clk (.o_clk(clk));

    bfp_compress_top #(
        .NUM_CH(NUM_CH), .IW(IW), .OW(OW), .PKT_LEN(PKT_LEN)
    ) UUT (
        .clk(clk), .i_rst_n(i_rst_n),
        .i_sel(i_sel), .i_sop(i_sop), .i_eop(i_eop), .i_vld(i_vld),
        .i_din_re(i_din_re), .i_din_im(i_din_im), .i_agc(i_agc),
        .o_sel(o_sel), .o_sop(o_sop), .o_eop(o_eop), .o_vld(o_vld),
        .o_dout_re(o_dout_re), .o_dout_im(o_dout_im),
        .o_shift(o_shift), .o_agc(o_agc)
    );

    tb_checker #(
        .NUM_CH(NUM_CH), .IW(IW), .OW(OW), .PKT_LEN(PKT_LEN)
    ) u_checker (
        .clk(clk), .i_rst_n(i_rst_n),
        .i_in_sel(i_sel), .i_in_sop(i_sop), .i_in_eop(i_eop), .i_in_vld(i_vld),
        .i_in_re(i_din_re), .i_in_im(i_din_im), .i_in_agc(i_agc),
        .i_out_sel(o_sel), .i_out_sop(o_sop), .i_out_eop(o_eop), .i_out_vld(o_vld),
        .i_out_re(o_dout_re), .i_out_im(o_dout_im),
        .i_out_shift(o_shift), .i_out_agc(o_agc),
        .o_errors(errors), .o_checks(checks),
        .o_beats_in(beats_in), .o_beats_out(beats_out)
    );

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------
    // Small samples stay below 2^(OW-1), large ones scale down by sc bits
    function automatic logic [IW-1:0] gen_sample(input int sc, input bit quiet);
        int v;
        v = $random(seed);
        if (quiet) begin
            v = v % (1 << (OW - 1));
        end else begin
            v = v >>> (32 - IW + sc);
        end
        return v[IW-1:0];
    endfunction

    // Loud channel index, or -1 for all large and -2 for all small
    task automatic send_packet(input int sc, input int loud, input int gap, input bit with_min);
        bit quiet;
        for (int b = 0; b < PKT_LEN; b++) begin
            @(posedge clk);
            i_vld <= 1'b1;
            i_sop <= (b == 0);
            i_eop <= (b == PKT_LEN - 1);
            i_sel <= 1'($random(seed));
            for (int ch = 0; ch < NUM_CH; ch++) begin
                quiet = (loud == -2) || (loud >= 0 && ch != loud);
                i_din_re[ch] <= gen_sample(sc, quiet);
                i_din_im[ch] <= gen_sample(sc, quiet);
                i_agc[ch]    <= 8'($random(seed));
            end
            if (with_min && b == 5) begin
                i_din_re[1] <= {1'b1, {(IW-1){1'b0}}};
            end
        end
        for (int g = 0; g < gap; g++) begin
            @(posedge clk);
            i_vld <= 1'b0;
            i_sop <= 1'b0;
            i_eop <= 1'b0;
            i_sel <= 1'($random(seed));
        end
    endtask

    task automatic finish_test(input string name);
        @(posedge clk);
        i_vld <= 1'b0;
        i_sop <= 1'b0;
        i_eop <= 1'b0;
        repeat (2) @(posedge clk);
        while (beats_out != beats_in) begin
            @(posedge clk);
        end
        @(posedge clk);
        test_num++;
        $display("Test %0d %s done, %0d errors", test_num, name, errors - errs_before);
        errs_before = errors;
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        seed        = 32'h38fb27e3;
        test_num    = 0;
        errs_before = 0;
        i_rst_n     = 1'b0;
        i_sel       = 1'b0;
        i_sop       = 1'b0;
        i_eop       = 1'b0;
        i_vld       = 1'b0;
        i_din_re    = '0;
        i_din_im    = '0;
        i_agc       = '0;
        repeat (3) @(posedge clk);
        i_rst_n <= 1'b1;

        repeat (10) @(posedge clk);
        finish_test("idle after reset");

        for (int p = 0; p < 3; p++) begin
            send_packet(0, -2, 1, 1'b0);
        end
        finish_test("small packets");

        send_packet(0, -1, 2, 1'b0);
        send_packet(3, -1, 2, 1'b0);
        send_packet(8, -1, 2, 1'b0);
        send_packet(14, -1, 2, 1'b1);
        finish_test("large and negative values");

        send_packet(4, 2, 1, 1'b0);
        send_packet(0, 0, 1, 1'b0);
        finish_test("one loud channel");

        send_packet(0, -1, 0, 1'b0);
        send_packet(10, -1, 0, 1'b0);
        send_packet(4, -1, 0, 1'b0);
        send_packet(12, -1, 0, 1'b0);
        finish_test("back-to-back packets");

        for (int p = 0; p < 4; p++) begin
            send_packet(($random(seed) & 15), -1, ($random(seed) & 3) % 3, 1'b0);
        end
        finish_test("strobe and sel passthrough");

        $display("Tests %0d, checks %0d, errors %0d", test_num, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: output beats did not drain within %0d cycles", TIMEOUT_CYCLES);
        $display("sim failed");
        $finish;
    end

endmodule

// File: flist.f
rtl/bfp_pkg.sv
rtl/channel_peak_detect.sv
rtl/block_exponent.sv
rtl/sample_delay_line.sv
rtl/block_shifter.sv
rtl/bfp_compress_top.sv
test/tb_clock_gen.sv
test/bfp_compress_assertions.sv
test/tb_checker.sv
test/tb_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run with Verilator, then search the log for the fail message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_top \
    -f flist.f -o sim_bin > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/sim_bin > sim.log 2>&1 || echo "sim failed" >> sim.log
cat sim.log

grep -q "sim failed" sim.log && { echo "Simulation FAILED"; exit 1; } || echo "Simulation PASSED"
